//--- filelist.f
common/core_pkg.sv
hw/decode/control.sv
hw/decode/imm_gen.sv
hw/regfile.sv
hw/alu.sv
hw/data_mem.sv
hw/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f

output=$(./obj_dir/Vrv_core_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
        exit 0
else
        exit 1
fi

//--- sim/rv_core_tb.sv
module rv_core_tb import core_pkg::*; ();

        localparam int CLK_PERIOD  = 40;
        localparam int DEPTH       = 64;
        localparam int TOTAL_INSTR = 49;        // instructions issued over all tests.

        logic    clk;
        logic    rst;
        logic    instr_valid;
        instr_t  instruction;
        retire_t retire;

        word_t model_regs [32];
        word_t model_mem [DEPTH];
        word_t model_pc;
        word_t lcg_state = 32'd77887;
        string cur_test;
        int    errors = 0;
        int    test_errors;
        int    tests_passed = 0;
        int    tests_failed = 0;

        rv_core #(
                .MEM_WORDS (DEPTH)
        ) UUT (
                .clk         (clk),
                .rst         (rst),
                .instr_valid (instr_valid),
                .instruction (instruction),
                .retire      (retire)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        initial begin
                #((TOTAL_INSTR + 50) * CLK_PERIOD);
                $display("timeout: run did not finish within %0d time units",
                         (TOTAL_INSTR + 50) * CLK_PERIOD);
                $display("TB FAILED");
                $finish;
        end

        ////////////////////////////////////////////////////////////
        // random numbers and instruction words
        ////////////////////////////////////////////////////////////

        function automatic word_t lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        function automatic logic [11:0] rand12();
                word_t r;
                r = lcg_next();
                return r[11:0];
        endfunction

        function automatic word_t sext12(input logic [11:0] v);
                return {{20{v[11]}}, v};
        endfunction

        // opposite signs order by the sign bit alone.
        function automatic word_t less_signed(input word_t a, input word_t b);
                if (a[31] != b[31])
                        return {31'b0, a[31]};
                return {31'b0, a < b};
        endfunction

        function automatic word_t shift_arith(input word_t a, input logic [4:0] sh);
                word_t fill;
                fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;  // vacated top bits.
                return (a >> sh) | fill;
        endfunction

        function automatic word_t r_word(input funct7_t f7, input funct3_t f3, input reg_addr_t rd,
                                         input reg_addr_t rs1, input reg_addr_t rs2);
                return {f7, rs2, rs1, f3, rd, OP_OP};
        endfunction

        function automatic word_t i_word(input opcode_t op, input funct3_t f3, input reg_addr_t rd,
                                         input reg_addr_t rs1, input logic [11:0] imm);
                return {imm, rs1, f3, rd, op};
        endfunction

        function automatic word_t s_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
                return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
        endfunction

        function automatic word_t b_word(input funct3_t f3, input reg_addr_t rs1,
                                         input reg_addr_t rs2, input logic [12:0] imm);
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
        endfunction

        function automatic word_t u_word(input logic [19:0] imm, input reg_addr_t rd);
                return {imm, rd, OP_LUI};
        endfunction

        ////////////////////////////////////////////////////////////
        // issue, check and per-test reporting
        ////////////////////////////////////////////////////////////

        task automatic check(input string what, input word_t expected, input word_t actual);
                assert (actual === expected)
                else begin
                        $display("FAIL %s %s: expected %h actual %h", cur_test, what,
                                 expected, actual);
                        errors++;
                end
        endtask

        // called on a falling edge, returns on the next one with the retire checked.
        task automatic issue_pc(input word_t word, input logic exp_we, input word_t exp_data,
                                input word_t next_pc);
                reg_addr_t rd;
                rd = word[11:7];
                instruction = word;
                instr_valid = 1'b1;
                @(negedge clk);
                instr_valid = 1'b0;
                check("retire.valid", 32'd1, {31'b0, retire.valid});
                check("retire.pc", model_pc, retire.pc);
                check("retire.rd", {27'b0, rd}, {27'b0, retire.rd});
                check("retire.we", {31'b0, exp_we}, {31'b0, retire.we});
                if (exp_we) begin
                        check("retire.data", exp_data, retire.data);
                        model_regs[rd] = exp_data;
                end
                model_pc = next_pc;
        endtask

        task automatic issue(input word_t word, input logic exp_we, input word_t exp_data);
                issue_pc(word, exp_we, exp_data, model_pc + 32'd4);
        endtask

        task automatic load_reg(input reg_addr_t rd, input word_t value);
                word_t upper;
                upper = (value + 32'h800) & 32'hffff_f000;  // rounds for the signed low part.
                issue(u_word(upper[31:12], rd), 1'b1, upper);
                issue(i_word(OP_IMM, F3_ADD, rd, rd, value[11:0]), 1'b1, value);
        endtask

        task automatic start_test(input string name);
                cur_test = name;
                test_errors = errors;
        endtask

        task automatic end_test();
                if (errors == test_errors) begin
                        tests_passed++;
                        $display("ok     %s", cur_test);
                end else begin
                        tests_failed++;
                        $display("error  %s: %0d mismatches", cur_test, errors - test_errors);
                end
        endtask

        ////////////////////////////////////////////////////////////
        // tests
        ////////////////////////////////////////////////////////////

        task automatic reset_check();
                start_test("reset");
                repeat (8) begin
                        @(negedge clk);
                        check("retire.valid in reset", 32'd0, {31'b0, retire.valid});
                end
                rst = 1'b0;
                @(negedge clk);
                issue(i_word(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd5), 1'b1, 32'd5);
                end_test();
        endtask

        task automatic alu_reg_ops();
                word_t a;
                word_t b;
                start_test("alu_reg");
                load_reg(5'd5, lcg_next());
                load_reg(5'd6, lcg_next());
                a = model_regs[5];
                b = model_regs[6];
                issue(r_word(F7_BASE, F3_ADD, 5'd7, 5'd5, 5'd6), 1'b1, a + b);
                issue(r_word(F7_ALT, F3_ADD, 5'd8, 5'd5, 5'd6), 1'b1, a - b);
                issue(r_word(F7_BASE, F3_AND, 5'd9, 5'd5, 5'd6), 1'b1, a & b);
                issue(r_word(F7_BASE, F3_OR, 5'd10, 5'd5, 5'd6), 1'b1, a | b);
                issue(r_word(F7_BASE, F3_XOR, 5'd11, 5'd5, 5'd6), 1'b1, a ^ b);
                issue(r_word(F7_BASE, F3_SLL, 5'd12, 5'd5, 5'd6), 1'b1, a << b[4:0]);
                issue(r_word(F7_BASE, F3_SR, 5'd13, 5'd5, 5'd6), 1'b1, a >> b[4:0]);
                issue(r_word(F7_ALT, F3_SR, 5'd14, 5'd5, 5'd6), 1'b1, shift_arith(a, b[4:0]));
                issue(r_word(F7_BASE, F3_SLT, 5'd15, 5'd5, 5'd6), 1'b1, less_signed(a, b));
                issue(r_word(F7_BASE, F3_SLTU, 5'd16, 5'd5, 5'd6), 1'b1, {31'b0, a < b});
                end_test();
        endtask

        task automatic alu_imm_ops();
                word_t       a;
                logic [11:0] imm;
                logic [11:0] r;
                logic [4:0]  sh;
                start_test("alu_imm");
                a = model_regs[5];
                imm = rand12() | 12'h800;               // negative.
                issue(i_word(OP_IMM, F3_ADD, 5'd8, 5'd5, imm), 1'b1, a + sext12(imm));
                imm = rand12();
                issue(i_word(OP_IMM, F3_SLT, 5'd9, 5'd5, imm), 1'b1,
                      less_signed(a, sext12(imm)));
                imm = rand12();
                issue(i_word(OP_IMM, F3_SLTU, 5'd10, 5'd5, imm), 1'b1, {31'b0, a < sext12(imm)});
                imm = rand12();
                issue(i_word(OP_IMM, F3_XOR, 5'd11, 5'd5, imm), 1'b1, a ^ sext12(imm));
                imm = rand12();
                issue(i_word(OP_IMM, F3_OR, 5'd12, 5'd5, imm), 1'b1, a | sext12(imm));
                imm = rand12();
                issue(i_word(OP_IMM, F3_AND, 5'd13, 5'd5, imm), 1'b1, a & sext12(imm));
                r = rand12();
                sh = r[4:0];
                issue(i_word(OP_IMM, F3_SLL, 5'd14, 5'd5, {7'b0, sh}), 1'b1, a << sh);
                issue(i_word(OP_IMM, F3_SR, 5'd15, 5'd5, {7'b0, sh}), 1'b1, a >> sh);
                issue(i_word(OP_IMM, F3_SR, 5'd16, 5'd5, {7'b0100000, sh}), 1'b1,
                      shift_arith(a, sh));
                end_test();
        endtask

        task automatic mem_roundtrip();
                logic [5:0] slot [4];
                word_t      r;
                reg_addr_t  rd;
                start_test("memory");
                for (int k = 0; k < 4; k++) begin
                        r = lcg_next();
                        slot[k] = {r[3:0], k[1:0]};    // low bits keep the words distinct.
                        load_reg(5'd10, lcg_next());
                        issue(s_word(5'd10, 5'd0, {4'b0, slot[k], 2'b00}), 1'b0, 32'd0);
                        model_mem[slot[k]] = model_regs[10];
                end
                for (int k = 0; k < 4; k++) begin
                        rd = reg_addr_t'(20 + k);
                        issue(i_word(OP_LOAD, F3_LW, rd, 5'd0, {4'b0, slot[k], 2'b00}), 1'b1,
                              model_mem[slot[k]]);
                end
                end_test();
        endtask

        task automatic branch_ops();
                start_test("branch");
                issue(i_word(OP_IMM, F3_ADD, 5'd12, 5'd0, 12'd1), 1'b1, 32'd1);
                issue_pc(b_word(F3_BEQ, 5'd5, 5'd5, 13'd8), 1'b0, 32'd0, model_pc + 32'd8);
                issue_pc(b_word(F3_BEQ, 5'd0, 5'd12, 13'd16), 1'b0, 32'd0, model_pc + 32'd4);
                issue_pc(b_word(F3_BNE, 5'd0, 5'd12, 13'h1ff4), 1'b0, 32'd0,
                         model_pc - 32'd12);                    // backward by 12.
                issue_pc(b_word(F3_BNE, 5'd5, 5'd5, 13'd8), 1'b0, 32'd0, model_pc + 32'd4);
                issue(i_word(OP_IMM, F3_ADD, 5'd13, 5'd12, 12'd2), 1'b1, 32'd3);
                end_test();
        endtask

        task automatic x0_and_nop();
                start_test("x0_nop");
                issue(i_word(OP_IMM, F3_ADD, 5'd0, 5'd12, 12'd123), 1'b0, 32'd0);
                issue(32'h002081d3, 1'b0, 32'd0);      // fadd.s f3, f1, f2.
                issue(r_word(F7_BASE, F3_ADD, 5'd14, 5'd0, 5'd0), 1'b1, 32'd0);
                end_test();
        endtask

        initial begin
                rst = 1'b1;
                instr_valid = 1'b0;
                instruction = '0;
                model_pc = '0;
                for (int i = 0; i < 32; i++) begin
                        model_regs[i] = '0;
                end
                reset_check();
                alu_reg_ops();
                alu_imm_ops();
                mem_roundtrip();
                branch_ops();
                x0_and_nop();
                $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d sva failures",
                         tests_passed + tests_failed, tests_passed, tests_failed, errors,
                         UUT.u_sva.failures);
                if (errors == 0 && UUT.u_sva.failures == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

endmodule

//--- sim/rv_core_sva.sv
module rv_core_sva import core_pkg::*; (
        input logic      clk,
        input logic      rst,
        input logic      instr_valid,
        input logic      is_branch,
        input reg_addr_t rs1_addr,
        input reg_addr_t rs2_addr,
        input word_t     rs1_data,
        input word_t     rs2_data,
        input retire_t   retire
);

        int    failures = 0;
        logic  retire_is_branch;                // lines up with retire.
        logic  have_last;
        logic  last_branch;
        word_t last_pc;

        always_ff @(posedge clk) begin
                if (rst) begin
                        retire_is_branch <= 1'b0;
                        have_last        <= 1'b0;
                end else begin
                        retire_is_branch <= instr_valid & is_branch;
                        if (retire.valid) begin
                                have_last   <= 1'b1;
                                last_pc     <= retire.pc;
                                last_branch <= retire_is_branch;
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // retire timing, x0 and pc rules
        ////////////////////////////////////////////////////////////

        strobe_retires: assert property (@(posedge clk) disable iff (rst)
                instr_valid |=> retire.valid)
        else begin
                $error("strobe not followed by a retire on the next cycle");
                failures++;
        end

        no_spurious_retire: assert property (@(posedge clk) disable iff (rst)
                !instr_valid |=> !retire.valid)
        else begin
                $error("retire without a strobe");
                failures++;
        end

        x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
                instr_valid |-> (rs1_addr != '0 || rs1_data == '0) &&
                                (rs2_addr != '0 || rs2_data == '0))
        else begin
                $error("register x0 read back a nonzero value");
                failures++;
        end

        pc_steps_by_four: assert property (@(posedge clk) disable iff (rst)
                (retire.valid && have_last && !last_branch) |-> retire.pc == last_pc + 32'd4)
        else begin
                $error("retire pc did not advance by 4 after a non-branch");
                failures++;
        end

endmodule

bind rv_core rv_core_sva u_sva (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .is_branch   (ctrl.is_branch),
        .rs1_addr    (instruction.rs1),
        .rs2_addr    (instruction.rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .retire      (retire)
);

//--- hw/rv_core.sv
module rv_core import core_pkg::*; #(
        parameter int MEM_WORDS = core_pkg::MEM_WORDS
) (
        input  logic    clk,
        input  logic    rst,
        input  logic    instr_valid,
        input  instr_t  instruction,
        output retire_t retire
);

        localparam int ADDR_W = $clog2(MEM_WORDS);

        control_t          ctrl;
        word_t             pc;
        word_t             pc_next;
        word_t             imm;
        word_t             rs1_data;
        word_t             rs2_data;
        word_t             alu_b;
        word_t             alu_result;
        word_t             mem_rdata;
        word_t             load_data;
        word_t             wb_data;
        logic              alu_equal;
        logic              take_branch;
        logic              rf_we;
        logic              mem_we;
        logic [ADDR_W-1:0] mem_addr;

        ////////////////////////////////////////////////////////////
        // decode and datapath
        ////////////////////////////////////////////////////////////

        control u_control (
                .instruction (instruction),
                .control     (ctrl)
        );

        imm_gen u_imm_gen (
                .instruction (instruction),
                .encoding    (ctrl.encoding),
                .imm         (imm)
        );

        regfile u_regfile (
                .clk      (clk),
                .rst      (rst),
                .rs1_addr (instruction.rs1),
                .rs2_addr (instruction.rs2),
                .rs1_data (rs1_data),
                .rs2_data (rs2_data),
                .we       (rf_we),
                .rd_addr  (instruction.rd),
                .rd_data  (wb_data)
        );

        assign alu_b = ctrl.alu_src ? imm : rs2_data;

        alu u_alu (
                .op     (ctrl.alu_op),
                .a      (rs1_data),
                .b      (alu_b),
                .result (alu_result),
                .equal  (alu_equal)
        );

        assign mem_addr = alu_result[ADDR_W+1:2];  // word index.

        data_mem #(
                .MEM_WORDS (MEM_WORDS)
        ) u_data_mem (
                .clk   (clk),
                .we    (mem_we),
                .addr  (mem_addr),
                .wdata (rs2_data),
                .rdata (mem_rdata)
        );

        assign rf_we  = instr_valid & ctrl.reg_write;
        assign mem_we = instr_valid & ctrl.mem_write;

        ////////////////////////////////////////////////////////////
        // write-back and next pc
        ////////////////////////////////////////////////////////////

        assign load_data = ctrl.mem_read ? mem_rdata : '0;

        always_comb begin
                if (ctrl.is_lui)
                        wb_data = imm;
                else if (ctrl.mem_to_reg)
                        wb_data = load_data;
                else
                        wb_data = alu_result;
        end

        assign take_branch = ctrl.is_branch & (alu_equal ^ ctrl.branch_ne);
        assign pc_next     = take_branch ? pc + imm : pc + 32'd4;

        always_ff @(posedge clk) begin
                if (rst)
                        pc <= '0;
                else if (instr_valid)
                        pc <= pc_next;
        end

        ////////////////////////////////////////////////////////////
        // retire record
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (rst)
                        retire.valid <= 1'b0;
                else
                        retire.valid <= instr_valid;

                if (instr_valid) begin
                        retire.pc   <= pc;              // pc of this instruction.
                        retire.rd   <= instruction.rd;
                        retire.we   <= ctrl.reg_write && instruction.rd != '0;
                        retire.data <= wb_data;
                end
        end

endmodule

//--- hw/data_mem.sv
module data_mem import core_pkg::*; #(
        parameter int MEM_WORDS = core_pkg::MEM_WORDS
) (
        input  logic                         clk,
        input  logic                         we,
        input  logic [$clog2(MEM_WORDS)-1:0] addr,
        input  word_t                        wdata,
        output word_t                        rdata
);

        word_t mem [MEM_WORDS];

        always_ff @(posedge clk) begin
                if (we) begin
                        mem[addr] <= wdata;
                end
        end

        assign rdata = mem[addr];               // same cycle read.

endmodule

//--- hw/alu.sv
module alu import core_pkg::*; (
        input  alu_op_t op,
        input  word_t   a,
        input  word_t   b,
        output word_t   result,
        output logic    equal
);

        logic [4:0] shamt;

        assign shamt = b[4:0];
        assign equal = (a == b);                // branch compare.

        always_comb begin
                case (op)
                        ALU_ADD:  result = a + b;
                        ALU_SUB:  result = a - b;
                        ALU_SLL:  result = a << shamt;
                        ALU_SLT: begin
                                result = {31'b0, $signed(a) < $signed(b)};
                        end
                        ALU_SLTU: begin
                                result = {31'b0, a < b};
                        end
                        ALU_XOR:  result = a ^ b;
                        ALU_SRL:  result = a >> shamt;
                        ALU_SRA: begin
                                result = word_t'($signed(a) >>> shamt);  // sign fill.
                        end
                        ALU_OR:   result = a | b;
                        ALU_AND:  result = a & b;
                        default:  result = '0;
                endcase
        end

endmodule

//--- hw/regfile.sv
module regfile import core_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  reg_addr_t rs1_addr,
        input  reg_addr_t rs2_addr,
        output word_t     rs1_data,
        output word_t     rs2_data,
        input  logic      we,
        input  reg_addr_t rd_addr,
        input  word_t     rd_data
);

        word_t regs [32];

        ////////////////////////////////////////////////////////////
        // write port
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && rd_addr != '0) begin  // x0 stays zero.
                        regs[rd_addr] <= rd_data;
                end
        end

        ////////////////////////////////////////////////////////////
        // read ports
        ////////////////////////////////////////////////////////////

        assign rs1_data = regs[rs1_addr];
        assign rs2_data = regs[rs2_addr];

endmodule

//--- hw/decode/imm_gen.sv
module imm_gen import core_pkg::*; (
        input  instr_t    instruction,
        input  encoding_t encoding,
        output word_t     imm
);

        word_t raw;

        assign raw = instruction;

        always_comb begin
                case (encoding)
                        I_TYPE: begin
                                imm = {{20{raw[31]}}, raw[31:20]};
                        end
                        S_TYPE: begin
                                imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
                        end
                        B_TYPE: begin
                                imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25],
                                       raw[11:8], 1'b0};        // even offsets only.
                        end
                        U_TYPE: begin
                                imm = {raw[31:12], 12'b0};
                        end
                        default: begin
                                imm = '0;                       // r-type has none.
                        end
                endcase
        end

endmodule

//--- hw/decode/control.sv
module control import core_pkg::*; (
        input  instr_t   instruction,
        output control_t control
);

        function automatic alu_op_t base_op(input funct3_t funct3);
                case (funct3)
                        F3_ADD:  return ALU_ADD;
                        F3_SLL:  return ALU_SLL;
                        F3_SLT:  return ALU_SLT;
                        F3_SLTU: return ALU_SLTU;
                        F3_XOR:  return ALU_XOR;
                        F3_SR:   return ALU_SRL;
                        F3_OR:   return ALU_OR;
                        F3_AND:  return ALU_AND;
                        default: return ALU_ADD;
                endcase
        endfunction

        always_comb begin : control_main_comb
                control = '0;

                case (instruction.opcode)
                        OP_OP:            control.encoding = R_TYPE;
                        OP_IMM, OP_LOAD:  control.encoding = I_TYPE;
                        OP_STORE:         control.encoding = S_TYPE;
                        OP_BRANCH:        control.encoding = B_TYPE;
                        OP_LUI:           control.encoding = U_TYPE;
                        OP_JAL:           control.encoding = J_TYPE;
                        default:          control.encoding = R_TYPE;  // nop.
                endcase

                case (instruction.opcode)
                        OP_LUI: begin
                                control.is_lui    = 1'b1;
                                control.reg_write = 1'b1;
                        end
                        OP_IMM: begin
                                control.alu_op    = base_op(instruction.funct3);
                                control.alu_src   = 1'b1;
                                control.reg_write = 1'b1;
                                if (instruction.funct3 == F3_SLL &&
                                    instruction.funct7 != F7_BASE) begin
                                        control.reg_write = 1'b0;
                                end
                                if (instruction.funct3 == F3_SR) begin
                                        if (instruction.funct7 == F7_ALT)
                                                control.alu_op = ALU_SRA;
                                        else if (instruction.funct7 != F7_BASE)
                                                control.reg_write = 1'b0;
                                end
                        end
                        OP_OP: begin
                                if (instruction.funct7 == F7_BASE) begin
                                        control.alu_op    = base_op(instruction.funct3);
                                        control.reg_write = 1'b1;
                                end else if (instruction.funct7 == F7_ALT) begin
                                        if (instruction.funct3 == F3_ADD) begin
                                                control.alu_op    = ALU_SUB;
                                                control.reg_write = 1'b1;
                                        end else if (instruction.funct3 == F3_SR) begin
                                                control.alu_op    = ALU_SRA;
                                                control.reg_write = 1'b1;
                                        end
                                end
                        end
                        OP_LOAD: begin
                                if (instruction.funct3 == F3_LW) begin
                                        control.alu_src    = 1'b1;   // base plus offset.
                                        control.mem_read   = 1'b1;
                                        control.mem_to_reg = 1'b1;
                                        control.reg_write  = 1'b1;
                                end
                        end
                        OP_STORE: begin
                                if (instruction.funct3 == F3_SW) begin
                                        control.alu_src   = 1'b1;
                                        control.mem_write = 1'b1;
                                end
                        end
                        OP_BRANCH: begin
                                if (instruction.funct3 == F3_BEQ) begin
                                        control.is_branch = 1'b1;
                                end else if (instruction.funct3 == F3_BNE) begin
                                        control.is_branch = 1'b1;
                                        control.branch_ne = 1'b1;
                                end
                        end
                        default: begin
                                // everything else retires as a nop
                        end
                endcase
        end

endmodule

//--- common/core_pkg.sv
package core_pkg;

        ////////////////////////////////////////////////////////////
        // widths and defaults
        ////////////////////////////////////////////////////////////

        localparam int MEM_WORDS = 256;         // default data memory depth in words.

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [2:0]  funct3_t;
        typedef logic [6:0]  funct7_t;
        typedef logic [6:0]  opcode_t;

        ////////////////////////////////////////////////////////////
        // instruction layout and decode types
        ////////////////////////////////////////////////////////////

        typedef struct packed {
                funct7_t   funct7;
                reg_addr_t rs2;
                reg_addr_t rs1;
                funct3_t   funct3;
                reg_addr_t rd;
                opcode_t   opcode;
        } instr_t;

        typedef enum logic [2:0] {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE
        } encoding_t;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_SLL,
                ALU_SLT,
                ALU_SLTU,
                ALU_XOR,
                ALU_SRL,
                ALU_SRA,
                ALU_OR,
                ALU_AND
        } alu_op_t;

        typedef struct packed {
                encoding_t encoding;
                alu_op_t   alu_op;
                logic      alu_src;             // immediate to alu.
                logic      mem_read;
                logic      mem_write;
                logic      reg_write;
                logic      mem_to_reg;
                logic      is_branch;
                logic      branch_ne;           // taken on inequality.
                logic      is_lui;
        } control_t;

        typedef struct packed {
                logic      valid;
                word_t     pc;
                reg_addr_t rd;
                logic      we;
                word_t     data;
        } retire_t;

        ////////////////////////////////////////////////////////////
        // opcodes and function codes
        ////////////////////////////////////////////////////////////

        localparam opcode_t OP_LUI    = 7'b0110111;
        localparam opcode_t OP_IMM    = 7'b0010011;
        localparam opcode_t OP_OP     = 7'b0110011;
        localparam opcode_t OP_LOAD   = 7'b0000011;
        localparam opcode_t OP_STORE  = 7'b0100011;
        localparam opcode_t OP_BRANCH = 7'b1100011;
        localparam opcode_t OP_JAL    = 7'b1101111;

        localparam funct3_t F3_ADD  = 3'b000;
        localparam funct3_t F3_SLL  = 3'b001;
        localparam funct3_t F3_SLT  = 3'b010;
        localparam funct3_t F3_SLTU = 3'b011;
        localparam funct3_t F3_XOR  = 3'b100;
        localparam funct3_t F3_SR   = 3'b101;  // srl and sra.
        localparam funct3_t F3_OR   = 3'b110;
        localparam funct3_t F3_AND  = 3'b111;
        localparam funct3_t F3_LW   = 3'b010;
        localparam funct3_t F3_SW   = 3'b010;
        localparam funct3_t F3_BEQ  = 3'b000;
        localparam funct3_t F3_BNE  = 3'b001;

        localparam funct7_t F7_BASE = 7'b0000000;
        localparam funct7_t F7_ALT  = 7'b0100000;  // sub and sra.

endpackage
